// ==== tlu_pkg.sv ====
// tlu controller package with widths, word types, trigger modes and FSM states
package tlu_pkg;

    localparam int DIVISOR = 8;  // TRIGGER_CLK cycles per serial bit
    localparam int WORD_W  = 32;
    localparam int NUM_W   = 31; // payload below the marker bit

    typedef logic [WORD_W-1:0]            data_word_t;
    typedef logic [WORD_W-1:0]            timestamp_t;
    typedef logic [NUM_W-1:0]             trigger_number_t;
    typedef logic [4:0]                   bit_count_t;  // 0 selects 31 bits
    typedef logic [$clog2(DIVISOR)-1:0]   period_cnt_t;

    typedef enum logic [1:0] {
        MODE_EXT        = 2'b00,
        MODE_EXT_ALT    = 2'b01,
        MODE_TLU_NODATA = 2'b10, // handshake only, never triggers here
        MODE_TLU_DATA   = 2'b11
    } trigger_mode_t;

    typedef enum logic [2:0] {
        IDLE             = 3'd0,
        SEND_COMMAND     = 3'd1,
        WAIT_TRIGGER_LOW = 3'd2,
        SEND_TLU_CLOCK   = 3'd3,
        LATCH_DATA       = 3'd4,
        WAIT_ACK         = 3'd5
    } tlu_state_t;

endpackage

// ==== tlu_if.sv ====
// tlu controller internal buses for the frozen configuration and the serial link
`timescale 1ns/1ps

interface cfg_if;
    import tlu_pkg::*;

    trigger_mode_t mode;
    bit_count_t    bit_count;       // never 0 on this bus
    logic          msb_first;
    logic          write_timestamp;

    modport cfg_src (output mode, output bit_count, output msb_first, output write_timestamp);
    modport cfg_dst (input mode, input bit_count, input msb_first, input write_timestamp);
endinterface

interface serial_if;
    import tlu_pkg::*;

    logic            clock_enable; // whole clocking phase
    logic            latch;        // one-cycle pulse
    logic            done;         // all bits sampled
    trigger_number_t number;       // valid from the cycle after latch

    // handshake FSM side
    modport ctrl (output clock_enable, output latch, input done, input number);

    // serial receiver side
    modport rx (input clock_enable, input latch, output done, output number);

    // data word block only watches the latch and the result
    modport mon (input latch, input number);
endinterface

// ==== tlu_config.sv ====
// tlu configuration register, follows software settings while idle and freezes them per trigger
`timescale 1ns/1ps

module tlu_config (
    input  logic                   TRIGGER_CLK,
    input  logic                   RESET,
    input  logic                   idle,
    input  tlu_pkg::trigger_mode_t trigger_mode,
    input  tlu_pkg::bit_count_t    trigger_bits,
    input  logic                   msb_first,
    input  logic                   write_timestamp,
    cfg_if.cfg_src                 cfg
);
    import tlu_pkg::*;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            cfg.mode            <= MODE_EXT;
            cfg.bit_count       <= bit_count_t'(NUM_W);
            cfg.msb_first       <= 1'b0;
            cfg.write_timestamp <= 1'b0;
        end
        else if (idle)
        begin
            cfg.mode <= trigger_mode;
            // 0 stands for the full 31 bit number
            if (trigger_bits == '0)
                cfg.bit_count <= bit_count_t'(NUM_W);
            else
                cfg.bit_count <= trigger_bits;
            cfg.msb_first       <= msb_first;
            cfg.write_timestamp <= write_timestamp;
        end
    end

endmodule

// ==== tlu_handshake_fsm.sv ====
// tlu handshake FSM, accepts triggers, runs the busy/clock phase and waits for both acknowledges
`timescale 1ns/1ps

module tlu_handshake_fsm (
    input  logic   TRIGGER_CLK,
    input  logic   RESET,
    input  logic   trigger,
    input  logic   trigger_flag,
    input  logic   trigger_veto,
    input  logic   trigger_enable,
    input  logic   trigger_acknowledge,
    input  logic   fifo_acknowledge,
    cfg_if.cfg_dst cfg,
    serial_if.ctrl ser,
    output logic   idle,
    output logic   accept,
    output logic   trigger_accepted_flag,
    output logic   trigger_data_write,
    output logic   fifo_preempt_req,
    output logic   tlu_busy
);
    import tlu_pkg::*;

    tlu_state_t state;
    tlu_state_t next;
    logic       ext_ok;
    logic       tlu_ok;
    logic       trig_ack_seen;
    logic       fifo_ack_seen;

    assign ext_ok = ((cfg.mode == MODE_EXT) || (cfg.mode == MODE_EXT_ALT))
                    && trigger_flag && !trigger_veto;
    assign tlu_ok = (cfg.mode == MODE_TLU_DATA) && trigger;

    assign idle   = (state == IDLE);
    assign accept = idle && trigger_enable && !trigger_acknowledge && !fifo_acknowledge
                    && (ext_ok || tlu_ok);

    // one cycle before the write in both modes
    assign ser.latch = (state == SEND_COMMAND) || (state == LATCH_DATA);

    always_comb
    begin
        next = state;
        case (state)
            IDLE:
            begin
                if (accept && ext_ok)
                    next = SEND_COMMAND;
                else if (accept)
                    next = WAIT_TRIGGER_LOW;
            end
            SEND_COMMAND:     next = WAIT_ACK;
            WAIT_TRIGGER_LOW: if (!trigger) next = SEND_TLU_CLOCK; // TLU saw busy
            SEND_TLU_CLOCK:   if (ser.done) next = LATCH_DATA;
            LATCH_DATA:       next = WAIT_ACK;
            WAIT_ACK:         if (trig_ack_seen && fifo_ack_seen) next = IDLE;
            default:          next = IDLE;
        endcase
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
        begin
            state                 <= IDLE;
            trigger_accepted_flag <= 1'b0;
            trigger_data_write    <= 1'b0;
            fifo_preempt_req      <= 1'b0;
            tlu_busy              <= 1'b0;
            ser.clock_enable      <= 1'b0;
        end
        else
        begin
            state                 <= next;
            trigger_accepted_flag <= accept;
            trigger_data_write    <= ser.latch;
            fifo_preempt_req      <= (next != IDLE);
            tlu_busy              <= (next != IDLE);
            ser.clock_enable      <= (next == SEND_TLU_CLOCK); // high exactly in SEND_TLU_CLOCK
        end
    end

    // acknowledges may arrive any time after acceptance
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || idle)
        begin
            trig_ack_seen <= 1'b0;
            fifo_ack_seen <= 1'b0;
        end
        else
        begin
            if (trigger_acknowledge)
                trig_ack_seen <= 1'b1;
            if (fifo_acknowledge)
                fifo_ack_seen <= 1'b1;
        end
    end

endmodule

// ==== tlu_serial_rx.sv ====
// tlu serial receiver, times the bit periods and assembles the trigger number
`timescale 1ns/1ps

module tlu_serial_rx (
    input  logic   TRIGGER_CLK,
    input  logic   RESET,
    input  logic   trigger,
    cfg_if.cfg_dst cfg,
    serial_if.rx   ser
);
    import tlu_pkg::*;

    period_cnt_t     period_cnt;
    bit_count_t      bit_cnt;    // bits sampled so far
    trigger_number_t sr;
    logic            sample;

    // last cycle of a bit period
    assign sample = ser.clock_enable && (period_cnt == period_cnt_t'(DIVISOR - 1));

    // rises with the final sample so the clock phase ends on time
    assign ser.done = (bit_cnt == cfg.bit_count)
                      || (sample && (bit_cnt == bit_count_t'(cfg.bit_count - 1'b1)));

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || !ser.clock_enable)
        begin
            period_cnt <= '0;
            bit_cnt    <= '0;
        end
        else
        begin
            period_cnt <= sample ? '0 : period_cnt + 1'b1;
            if (sample)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // msb first shifts up from bit 0, lsb first shifts down from the top
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (!ser.clock_enable && !ser.latch)
            sr <= '0;                             // fresh start, upper bits stay zero
        else if (sample && cfg.msb_first)
            sr <= {sr[NUM_W-2:0], trigger};
        else if (sample)
            sr <= {trigger, sr[NUM_W-1:1]};
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (ser.latch)
        begin
            if (cfg.msb_first)
                ser.number <= sr;
            else
                ser.number <= sr >> (NUM_W - int'(cfg.bit_count)); // align first bit to bit 0
        end
    end

endmodule

// ==== tlu_data_word.sv ====
// tlu data word block, timestamp and trigger counter with capture and output word select
`timescale 1ns/1ps

module tlu_data_word (
    input  logic                TRIGGER_CLK,
    input  logic                RESET,
    input  logic                tlu_reset_flag,
    input  logic                accept,
    input  logic                counter_set,
    input  tlu_pkg::timestamp_t counter_set_value,
    cfg_if.cfg_dst              cfg,
    serial_if.mon               ser,
    output tlu_pkg::timestamp_t timestamp,
    output tlu_pkg::data_word_t trigger_data
);
    import tlu_pkg::*;

    timestamp_t      trigger_counter;
    timestamp_t      timestamp_cap;
    timestamp_t      counter_cap;
    trigger_number_t payload;    // counter or timestamp part of the word
    logic            use_number;

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET || tlu_reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (RESET)
            trigger_counter <= '0;
        else if (counter_set)                     // load wins over increment
            trigger_counter <= counter_set_value;
        else if (accept)
            trigger_counter <= trigger_counter + 1'b1;
    end

    // values closest to the trigger, counter before its increment
    always_ff @(posedge TRIGGER_CLK)
    begin
        if (accept)
        begin
            timestamp_cap <= timestamp;
            counter_cap   <= trigger_counter;
        end
    end

    always_ff @(posedge TRIGGER_CLK)
    begin
        if (ser.latch)
            payload <= cfg.write_timestamp ? timestamp_cap[NUM_W-1:0] : counter_cap[NUM_W-1:0];
    end

    assign use_number   = !cfg.write_timestamp && (cfg.mode == MODE_TLU_DATA);
    assign trigger_data = {1'b1, use_number ? ser.number : payload}; // bit 31 marks the word

endmodule

// ==== tlu_controller.sv ====
// tlu controller top, connects config, handshake FSM, serial receiver and data word block
`timescale 1ns/1ps

module tlu_controller (
    input  logic                   TRIGGER_CLK,
    input  logic                   RESET,
    input  logic                   trigger,
    input  logic                   trigger_flag,
    input  logic                   trigger_veto,
    input  logic                   trigger_enable,
    input  logic                   trigger_acknowledge,
    input  logic                   fifo_acknowledge,
    input  tlu_pkg::trigger_mode_t trigger_mode,
    input  tlu_pkg::bit_count_t    trigger_bits,
    input  logic                   msb_first,
    input  logic                   write_timestamp,
    input  logic                   tlu_reset_flag,
    input  logic                   counter_set,
    input  tlu_pkg::timestamp_t    counter_set_value,
    output tlu_pkg::data_word_t    trigger_data,
    output logic                   trigger_data_write,
    output logic                   fifo_preempt_req,
    output logic                   trigger_accepted_flag,
    output logic                   tlu_busy,
    output logic                   tlu_clock_enable,
    output tlu_pkg::timestamp_t    timestamp
);

    logic idle;
    logic accept;

    cfg_if    cfg_bus ();
    serial_if ser_bus ();

    assign tlu_clock_enable = ser_bus.clock_enable; // TLU clock gate

    tlu_config u_config (
        .TRIGGER_CLK     (TRIGGER_CLK),
        .RESET           (RESET),
        .idle            (idle),
        .trigger_mode    (trigger_mode),
        .trigger_bits    (trigger_bits),
        .msb_first       (msb_first),
        .write_timestamp (write_timestamp),
        .cfg             (cfg_bus.cfg_src)
    );

    tlu_handshake_fsm u_fsm (
        .TRIGGER_CLK           (TRIGGER_CLK),
        .RESET                 (RESET),
        .trigger               (trigger),
        .trigger_flag          (trigger_flag),
        .trigger_veto          (trigger_veto),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .fifo_acknowledge      (fifo_acknowledge),
        .cfg                   (cfg_bus.cfg_dst),
        .ser                   (ser_bus.ctrl),
        .idle                  (idle),
        .accept                (accept),
        .trigger_accepted_flag (trigger_accepted_flag),
        .trigger_data_write    (trigger_data_write),
        .fifo_preempt_req      (fifo_preempt_req),
        .tlu_busy              (tlu_busy)
    );

    tlu_serial_rx u_serial_rx (
        .TRIGGER_CLK (TRIGGER_CLK),
        .RESET       (RESET),
        .trigger     (trigger),
        .cfg         (cfg_bus.cfg_dst),
        .ser         (ser_bus.rx)
    );

    tlu_data_word u_data_word (
        .TRIGGER_CLK       (TRIGGER_CLK),
        .RESET             (RESET),
        .tlu_reset_flag    (tlu_reset_flag),
        .accept            (accept),
        .counter_set       (counter_set),
        .counter_set_value (counter_set_value),
        .cfg               (cfg_bus.cfg_dst),
        .ser               (ser_bus.mon),
        .timestamp         (timestamp),
        .trigger_data      (trigger_data)
    );

endmodule

// ==== tb_tlu_assert.sv ====
// tlu controller protocol checker for strobe widths and busy coverage of clock and write
`timescale 1ns/1ps

module tb_tlu_assert (
    input logic TRIGGER_CLK,
    input logic RESET,
    input logic trigger_accepted_flag,
    input logic trigger_data_write,
    input logic tlu_busy,
    input logic tlu_clock_enable
);

    int fail_count = 0;  // assertion failures so far

    accepted_pulse: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_accepted_flag |=> !trigger_accepted_flag)
        else
        begin
            fail_count++;
            $error("trigger_accepted_flag high for more than one cycle");
        end

    write_pulse: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_data_write |=> !trigger_data_write)
        else
        begin
            fail_count++;
            $error("trigger_data_write high for more than one cycle");
        end

    // TLU clock only runs inside a busy phase
    clock_in_busy: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        tlu_clock_enable |-> tlu_busy)
        else
        begin
            fail_count++;
            $error("tlu_clock_enable high while tlu_busy is low");
        end

    write_in_busy: assert property (@(posedge TRIGGER_CLK) disable iff (RESET)
        trigger_data_write |-> tlu_busy)
        else
        begin
            fail_count++;
            $error("trigger_data_write high while tlu_busy is low");
        end

endmodule

bind tlu_controller tb_tlu_assert u_assert (
    .TRIGGER_CLK           (TRIGGER_CLK),
    .RESET                 (RESET),
    .trigger_accepted_flag (trigger_accepted_flag),
    .trigger_data_write    (trigger_data_write),
    .tlu_busy              (tlu_busy),
    .tlu_clock_enable      (tlu_clock_enable)
);

// ==== tb_tlu_controller.sv ====
// tlu controller testbench with random triggers, a TLU responder and a reference model
`timescale 1ns/1ps

module tb_tlu_controller;
    import tlu_pkg::*;

    localparam logic [31:0] SEED         = 32'hc170_8240;
    localparam int          HALF_PERIOD  = 2;  // 4 ns clock
    localparam int          RESET_CYCLES = 10;
    localparam int          FLAG_TIMEOUT = 4;
    localparam int          TLU_TIMEOUT  = 600;
    localparam int          BUSY_TIMEOUT = 8;

    logic            TRIGGER_CLK = 1'b0;
    logic            RESET;
    logic            trigger;
    logic            trigger_flag;
    logic            trigger_veto;
    logic            trigger_enable;
    logic            trigger_acknowledge;
    logic            fifo_acknowledge;
    trigger_mode_t   trigger_mode;
    bit_count_t      trigger_bits;
    logic            msb_first;
    logic            write_timestamp;
    logic            tlu_reset_flag;
    logic            counter_set;
    timestamp_t      counter_set_value;
    data_word_t      trigger_data;
    logic            trigger_data_write;
    logic            fifo_preempt_req;
    logic            trigger_accepted_flag;
    logic            tlu_busy;
    logic            tlu_clock_enable;
    timestamp_t      timestamp;

    integer          seed;
    int              errors;
    int              checks;
    int              tests;
    logic            timed_out;
    timestamp_t      model_count;  // expected trigger counter

    always #(HALF_PERIOD) TRIGGER_CLK = ~TRIGGER_CLK;

    tlu_controller DUT (
        .TRIGGER_CLK           (TRIGGER_CLK),
        .RESET                 (RESET),
        .trigger               (trigger),
        .trigger_flag          (trigger_flag),
        .trigger_veto          (trigger_veto),
        .trigger_enable        (trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .fifo_acknowledge      (fifo_acknowledge),
        .trigger_mode          (trigger_mode),
        .trigger_bits          (trigger_bits),
        .msb_first             (msb_first),
        .write_timestamp       (write_timestamp),
        .tlu_reset_flag        (tlu_reset_flag),
        .counter_set           (counter_set),
        .counter_set_value     (counter_set_value),
        .trigger_data          (trigger_data),
        .trigger_data_write    (trigger_data_write),
        .fifo_preempt_req      (fifo_preempt_req),
        .trigger_accepted_flag (trigger_accepted_flag),
        .tlu_busy              (tlu_busy),
        .tlu_clock_enable      (tlu_clock_enable),
        .timestamp             (timestamp)
    );

    function automatic int unsigned pick(input int unsigned range);
        pick = $unsigned($random(seed)) % range;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic end_test(input string name, input int err0, input int chk0);
        tests++;
        $display("%-12s done, %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    // only called while idle so the config register follows a cycle later
    task automatic apply_settings(input trigger_mode_t mode, input bit_count_t bits,
                                  input logic msb, input logic wts);
        @(posedge TRIGGER_CLK);
        trigger_mode    <= mode;
        trigger_bits    <= bits;
        msb_first       <= msb;
        write_timestamp <= wts;
        repeat (2) @(posedge TRIGGER_CLK);
    endtask

    task automatic ext_trigger(input string name, output data_word_t word,
                               output timestamp_t ts_flag);
        int   n;
        logic seen;
        n       = 0;
        seen    = 1'b0;
        word    = '0;
        ts_flag = '0;
        @(posedge TRIGGER_CLK);
        trigger_flag <= 1'b1;       // single cycle flag
        @(posedge TRIGGER_CLK);
        trigger_flag <= 1'b0;
        while (!seen && n < FLAG_TIMEOUT)
        begin
            @(negedge TRIGGER_CLK);
            seen = trigger_accepted_flag;
            n++;
        end
        if (!seen)
        begin
            report_timeout({"trigger_accepted_flag in ", name});
            return;
        end
        ts_flag = timestamp;        // timestamp during the accepted flag
        @(negedge TRIGGER_CLK);
        check_value({name, " write strobe"}, 32'd1, {31'd0, trigger_data_write});
        word = trigger_data;
    endtask

    // TLU responder drops trigger on busy and shifts out bit k in period k
    task automatic tlu_trigger(input string name, input trigger_number_t num, input int nbits,
                               input logic msb, output data_word_t word, output int en_cycles);
        int              n;
        int              idx;
        logic            busy_s;
        logic            en_s;
        logic            got;
        trigger_number_t shifted;
        n         = 0;
        got       = 1'b0;
        en_cycles = 0;
        word      = '0;
        @(posedge TRIGGER_CLK);
        trigger <= 1'b1;
        while (!got && n < TLU_TIMEOUT)
        begin
            @(negedge TRIGGER_CLK);
            busy_s = tlu_busy;
            en_s   = tlu_clock_enable;
            if (en_s)
                en_cycles++;
            if (trigger_data_write)
            begin
                got  = 1'b1;
                word = trigger_data;
            end
            idx     = en_cycles / DIVISOR;
            shifted = num >> (msb ? (nbits - 1 - idx) : idx);
            @(posedge TRIGGER_CLK);
            if (en_s && idx < nbits)
                trigger <= shifted[0];
            else if (busy_s)
                trigger <= 1'b0;
            n++;
        end
        if (!got)
            report_timeout({"trigger_data_write in ", name});
    endtask

    // acknowledges after random delays with busy held until both arrived
    task automatic give_acks(input string name, input int d_trig, input int d_fifo,
                             input logic poke);
        int   c;
        int   n;
        int   last;
        logic busy_s;
        last = (d_trig > d_fifo) ? d_trig : d_fifo;
        for (c = 0; c <= last; c++)
        begin
            @(posedge TRIGGER_CLK);
            trigger_acknowledge <= (c == d_trig);
            fifo_acknowledge    <= (c == d_fifo);
            trigger_flag        <= poke && (c == 1);  // second trigger attempt
            @(negedge TRIGGER_CLK);
            checks++;
            assert (tlu_busy && fifo_preempt_req && !trigger_accepted_flag)
            else
            begin
                $display("busy released or second trigger accepted before both acks in %s",
                         name);
                errors++;
            end
        end
        @(posedge TRIGGER_CLK);
        trigger_acknowledge <= 1'b0;
        fifo_acknowledge    <= 1'b0;
        trigger_flag        <= 1'b0;
        n      = 0;
        busy_s = 1'b1;
        while (busy_s && n < BUSY_TIMEOUT)
        begin
            @(negedge TRIGGER_CLK);
            busy_s = tlu_busy;
            n++;
        end
        if (busy_s)
            report_timeout({"tlu_busy to fall in ", name});
    endtask

    task automatic count_ext_triggers();
        data_word_t word;
        timestamp_t ts;
        int         i;
        int         err0;
        int         chk0;
        err0 = errors;
        chk0 = checks;
        // the other external tests run in MODE_EXT
        apply_settings(MODE_EXT_ALT, bit_count_t'(0), 1'b0, 1'b0);
        @(posedge TRIGGER_CLK);
        counter_set_value <= $random(seed);
        counter_set       <= 1'b1;
        @(posedge TRIGGER_CLK);
        counter_set <= 1'b0;
        model_count = counter_set_value;
        for (i = 0; i < 12 && !timed_out; i++)
        begin
            repeat (pick(4)) @(posedge TRIGGER_CLK);
            ext_trigger("ext_counter", word, ts);
            if (timed_out)
                break;
            check_value("ext_counter word", {1'b1, model_count[NUM_W-1:0]}, word);
            model_count = model_count + 1;
            give_acks("ext_counter", pick(8), pick(8), 1'b0);
        end
        end_test("ext_counter", err0, chk0);
    endtask

    task automatic block_flags();
        data_word_t  word;
        timestamp_t  ts;
        int unsigned kind;
        int          i;
        int          c;
        int          err0;
        int          chk0;
        err0 = errors;
        chk0 = checks;
        apply_settings(MODE_EXT, bit_count_t'(0), 1'b0, 1'b0);
        for (i = 0; i < 9; i++)
        begin
            kind = (i < 4) ? i : pick(4);  // every blocking case at least once
            @(posedge TRIGGER_CLK);
            trigger_veto        <= (kind == 0);
            trigger_enable      <= (kind != 1);
            trigger_acknowledge <= (kind == 2);  // held high while idle
            fifo_acknowledge    <= (kind == 3);
            @(posedge TRIGGER_CLK);
            trigger_flag <= 1'b1;
            @(posedge TRIGGER_CLK);
            trigger_flag <= 1'b0;
            for (c = 0; c < 4; c++)
            begin
                @(negedge TRIGGER_CLK);
                checks++;
                assert (!trigger_accepted_flag && !trigger_data_write)
                else
                begin
                    $display("blocked flag was accepted or written, blocking case %0d", kind);
                    errors++;
                end
            end
            @(posedge TRIGGER_CLK);
            trigger_veto        <= 1'b0;
            trigger_enable      <= 1'b1;
            trigger_acknowledge <= 1'b0;
            fifo_acknowledge    <= 1'b0;
        end
        // counter must not have moved
        ext_trigger("blocked", word, ts);
        if (!timed_out)
        begin
            check_value("blocked word", {1'b1, model_count[NUM_W-1:0]}, word);
            model_count = model_count + 1;
            give_acks("blocked", pick(8), pick(8), 1'b0);
        end
        end_test("blocked", err0, chk0);
    endtask

    task automatic receive_tlu_numbers();
        data_word_t      word;
        trigger_number_t num;
        bit_count_t      bits;
        logic            msb;
        int              nbits;
        int              en_cycles;
        int              i;
        int              err0;
        int              chk0;
        err0 = errors;
        chk0 = checks;
        for (i = 0; i < 8 && !timed_out; i++)
        begin
            bits  = (i == 0) ? bit_count_t'(0) : bit_count_t'(pick(32));
            nbits = (bits == 0) ? NUM_W : int'(bits);   // 0 means a full 31 bit number
            msb   = (pick(2) == 1);
            num   = trigger_number_t'($random(seed))
                    & trigger_number_t'((32'h1 << nbits) - 32'h1);
            apply_settings(MODE_TLU_DATA, bits, msb, 1'b0);
            tlu_trigger("tlu_data", num, nbits, msb, word, en_cycles);
            if (timed_out)
                break;
            check_value("tlu_data word", {1'b1, num}, word);
            check_value("tlu_data clock cycles", nbits * DIVISOR, en_cycles);
            model_count = model_count + 1;
            give_acks("tlu_data", pick(8), pick(8), 1'b0);
        end
        end_test("tlu_data", err0, chk0);
    endtask

    task automatic stamp_triggers();
        data_word_t word;
        timestamp_t ts;
        int         i;
        int         err0;
        int         chk0;
        err0 = errors;
        chk0 = checks;
        apply_settings(MODE_EXT, bit_count_t'(0), 1'b0, 1'b1);
        for (i = 0; i < 6 && !timed_out; i++)
        begin
            if (i == 3)
            begin
                @(posedge TRIGGER_CLK);
                tlu_reset_flag <= 1'b1;
                @(posedge TRIGGER_CLK);
                tlu_reset_flag <= 1'b0;
                @(negedge TRIGGER_CLK);
                check_value("timestamp after reset flag", 32'd0, timestamp);
                @(negedge TRIGGER_CLK);
                check_value("timestamp counting again", 32'd1, timestamp);
            end
            repeat (pick(16)) @(posedge TRIGGER_CLK);
            ext_trigger("timestamp", word, ts);
            if (timed_out)
                break;
            ts = ts - 1;    // captured one cycle before the flag
            check_value("timestamp word", {1'b1, ts[NUM_W-1:0]}, word);
            model_count = model_count + 1;
            give_acks("timestamp", pick(8), pick(8), 1'b0);
        end
        end_test("timestamp", err0, chk0);
    endtask

    task automatic hold_off_acks();
        data_word_t word;
        timestamp_t ts;
        int         i;
        int         err0;
        int         chk0;
        err0 = errors;
        chk0 = checks;
        apply_settings(MODE_EXT, bit_count_t'(0), 1'b0, 1'b0);
        for (i = 0; i < 5 && !timed_out; i++)
        begin
            ext_trigger("ack_holdoff", word, ts);
            if (timed_out)
                break;
            check_value("ack_holdoff word", {1'b1, model_count[NUM_W-1:0]}, word);
            model_count = model_count + 1;
            give_acks("ack_holdoff", 2 + pick(6), 2 + pick(6), 1'b1);
        end
        end_test("ack_holdoff", err0, chk0);
    endtask

    initial
    begin
        seed                = SEED;
        errors              = 0;
        checks              = 0;
        tests               = 0;
        timed_out           = 1'b0;
        model_count         = '0;
        RESET               = 1'b1;
        trigger             = 1'b0;
        trigger_flag        = 1'b0;
        trigger_veto        = 1'b0;
        trigger_enable      = 1'b1;
        trigger_acknowledge = 1'b0;
        fifo_acknowledge    = 1'b0;
        trigger_mode        = MODE_EXT;
        trigger_bits        = '0;
        msb_first           = 1'b0;
        write_timestamp     = 1'b0;
        tlu_reset_flag      = 1'b0;
        counter_set         = 1'b0;
        counter_set_value   = '0;
        repeat (RESET_CYCLES) @(posedge TRIGGER_CLK);
        RESET <= 1'b0;
        @(negedge TRIGGER_CLK);
        check_value("outputs after reset", 32'd0, {27'd0, trigger_data_write,
                    trigger_accepted_flag, tlu_busy, tlu_clock_enable, fifo_preempt_req});
        if (!timed_out)
            count_ext_triggers();
        if (!timed_out)
            block_flags();
        if (!timed_out)
            receive_tlu_numbers();
        if (!timed_out)
            stamp_triggers();
        if (!timed_out)
            hold_off_acks();
        errors = errors + DUT.u_assert.fail_count;  // protocol assertion failures
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== flist.f ====
tlu_pkg.sv
tlu_if.sv
tlu_config.sv
tlu_handshake_fsm.sv
tlu_serial_rx.sv
tlu_data_word.sv
tlu_controller.sv
tb_tlu_assert.sv
tb_tlu_controller.sv

// ==== Makefile ====
# Verilator build and run of the TLU controller testbench

VERILATOR ?= verilator
TOP       ?= tb_tlu_controller
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
